// ==== include/uart_proc_macros.svh ====
`ifndef UART_PROC_MACROS_SVH
`define UART_PROC_MACROS_SVH

// integer division, rounding towards zero
`define floor_div(num, den) ((num) / (den))

// integer division, rounding up
`define ceil_div(num, den) (((num) + (den) - 1) / (den))

// clocks per serial bit, rounded to the nearest whole clock
// half the baud rate is added before the division
`define clk_per_bit(clk_hz, baud) `floor_div((clk_hz) + `ceil_div((baud), 2), (baud))

`endif

// ==== logic/uart_proc_pkg.sv ====
`default_nettype none

package uart_proc_pkg;

    // data bits per 8N1 frame
    localparam int UART_WIDTH = 8;

    // command and result words, two serial bytes each
    localparam int INP_WIDTH = 16;
    localparam int OUT_WIDTH = 16;

    // command layout: opcode in the top bits, operand below
    localparam int OPCODE_WIDTH = 2;
    localparam int OPERAND_WIDTH = INP_WIDTH - OPCODE_WIDTH;

    typedef logic [UART_WIDTH-1:0] uart_byte_t;
    typedef logic [INP_WIDTH-1:0] cmd_word_t;
    // also the accumulator type
    typedef logic [OUT_WIDTH-1:0] result_word_t;
    typedef logic [OPERAND_WIDTH-1:0] operand_t;

    typedef enum logic [OPCODE_WIDTH-1:0] {
        OP_LOAD  = 2'd0,
        OP_ADD   = 2'd1,
        OP_RUN   = 2'd2,
        OP_CLEAR = 2'd3
    } opcode_e;

endpackage

`default_nettype wire

// ==== logic/uart_rx.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_rx #(
    parameter int CLKS_PER_BIT = 16
) (
    input  wire                       clk,
    input  wire                       arstn,
    input  wire                       rxd,
    input  wire                       rx_ready,
    output uart_proc_pkg::uart_byte_t rx_data,
    output logic                      rx_valid,
    output logic                      rx_busy,
    output logic                      frame_error,
    output logic                      overrun_error
);
    localparam int CNT_W = $clog2(CLKS_PER_BIT);
    localparam int IDX_W = $clog2(uart_proc_pkg::UART_WIDTH);

    typedef enum logic [1:0] {
        S_IDLE,
        S_START,
        S_DATA,
        S_STOP
    } state_e;

    state_e                    state;
    logic [CNT_W-1:0]          cnt;
    logic [IDX_W-1:0]          bit_idx;
    uart_proc_pkg::uart_byte_t shreg;
    logic                      rxd_meta;
    logic                      rxd_sync;
    logic                      bit_end;
    logic                      half_bit;
    logic                      stop_sample;
    logic                      hold_busy;

    // two-flop synchroniser, line idles high
    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            rxd_meta <= 1'b1;
            rxd_sync <= 1'b1;
        end else begin
            rxd_meta <= rxd;
            rxd_sync <= rxd_meta;
        end
    end

    assign bit_end  = (cnt == CNT_W'(CLKS_PER_BIT - 1));
    assign half_bit = (cnt == CNT_W'(CLKS_PER_BIT / 2 - 1));
    assign rx_busy  = (state != S_IDLE);

    // middle of the stop bit
    assign stop_sample = (state == S_STOP) && bit_end;
    // held byte not taken this cycle, so a new one has nowhere to go
    assign hold_busy = rx_valid && !rx_ready;

    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            state         <= S_IDLE;
            cnt           <= '0;
            bit_idx       <= '0;
            rx_valid      <= 1'b0;
            frame_error   <= 1'b0;
            overrun_error <= 1'b0;
        end else begin
            frame_error   <= 1'b0;
            overrun_error <= 1'b0;
            if (rx_valid && rx_ready) begin
                rx_valid <= 1'b0;
            end
            case (state)
                S_IDLE: begin
                    cnt <= '0;
                    if (!rxd_sync) begin
                        state <= S_START;
                    end
                end
                S_START: begin
                    cnt <= cnt + 1'b1;
                    // recheck at half a bit, a short glitch goes back to idle
                    if (half_bit) begin
                        cnt     <= '0;
                        bit_idx <= '0;
                        state   <= rxd_sync ? S_IDLE : S_DATA;
                    end
                end
                S_DATA: begin
                    cnt <= cnt + 1'b1;
                    if (bit_end) begin
                        cnt     <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == IDX_W'(uart_proc_pkg::UART_WIDTH - 1)) begin
                            state <= S_STOP;
                        end
                    end
                end
                S_STOP: begin
                    cnt <= cnt + 1'b1;
                    if (bit_end) begin
                        cnt   <= '0;
                        state <= S_IDLE;
                        if (!rxd_sync) begin
                            frame_error <= 1'b1;
                        end else if (hold_busy) begin
                            overrun_error <= 1'b1;
                        end else begin
                            rx_valid <= 1'b1;
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // data bits arrive lsb first, shift in from the top
    always_ff @(posedge clk) begin
        if (state == S_DATA && bit_end) begin
            shreg <= {rxd_sync, shreg[uart_proc_pkg::UART_WIDTH-1:1]};
        end
        if (stop_sample && rxd_sync && !hold_busy) begin
            rx_data <= shreg;
        end
    end

    // held byte keeps its value until the packer takes it
    assert property (@(posedge clk) disable iff (!arstn)
        rx_valid && !rx_ready |=> rx_valid && $stable(rx_data));

    // a dropped byte is reported as one error kind only
    assert property (@(posedge clk) disable iff (!arstn)
        !(frame_error && overrun_error));

endmodule

`default_nettype wire

// ==== logic/uart_tx.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_tx #(
    parameter int CLKS_PER_BIT = 16
) (
    input  wire                       clk,
    input  wire                       arstn,
    input  wire uart_proc_pkg::uart_byte_t tx_data,
    input  wire                       tx_valid,
    output logic                      tx_ready,
    output logic                      txd,
    output logic                      tx_busy
);
    localparam int CNT_W = $clog2(CLKS_PER_BIT);
    localparam int IDX_W = $clog2(uart_proc_pkg::UART_WIDTH);

    typedef enum logic [1:0] {
        S_IDLE,
        S_START,
        S_DATA,
        S_STOP
    } state_e;

    state_e                    state;
    logic [CNT_W-1:0]          cnt;
    logic [IDX_W-1:0]          bit_idx;
    uart_proc_pkg::uart_byte_t shreg;
    logic                      bit_end;

    assign bit_end  = (cnt == CNT_W'(CLKS_PER_BIT - 1));
    // one byte per frame, accepted only from idle
    assign tx_ready = (state == S_IDLE);
    assign tx_busy  = (state != S_IDLE);

    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            state   <= S_IDLE;
            cnt     <= '0;
            bit_idx <= '0;
            txd     <= 1'b1;
        end else begin
            cnt <= bit_end ? '0 : cnt + 1'b1;
            case (state)
                S_IDLE: begin
                    cnt <= '0;
                    // start bit goes out on the accept edge
                    if (tx_valid) begin
                        txd   <= 1'b0;
                        state <= S_START;
                    end
                end
                S_START: begin
                    if (bit_end) begin
                        bit_idx <= '0;
                        txd     <= shreg[0];
                        state   <= S_DATA;
                    end
                end
                S_DATA: begin
                    if (bit_end) begin
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == IDX_W'(uart_proc_pkg::UART_WIDTH - 1)) begin
                            txd   <= 1'b1;
                            state <= S_STOP;
                        end else begin
                            txd <= shreg[0];
                        end
                    end
                end
                S_STOP: begin
                    // frame ends after ten full bit periods
                    if (bit_end) begin
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // lsb first, next bit always waits in shreg[0]
    always_ff @(posedge clk) begin
        if (tx_valid && tx_ready) begin
            shreg <= tx_data;
        end else if (bit_end && (state == S_START || state == S_DATA)) begin
            shreg <= shreg >> 1;
        end
    end

    // line must rest at the mark level between frames
    assert property (@(posedge clk) disable iff (!arstn)
        state == S_IDLE |-> txd);

endmodule

`default_nettype wire

// ==== logic/byte_packer.sv ====
`timescale 1ns/1ps
`default_nettype none

module byte_packer (
    input  wire                       clk,
    input  wire                       arstn,
    input  wire uart_proc_pkg::uart_byte_t rx_data,
    input  wire                       rx_valid,
    input  wire                       cmd_ready,
    output logic                      rx_ready,
    output uart_proc_pkg::cmd_word_t  cmd,
    output logic                      cmd_valid
);
    localparam int BW = uart_proc_pkg::UART_WIDTH;

    // set once the low byte is in
    logic hi_half;
    logic take;

    // stall the receiver while a full word waits
    assign rx_ready = !cmd_valid;
    assign take     = rx_valid && rx_ready;

    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            hi_half   <= 1'b0;
            cmd_valid <= 1'b0;
        end else begin
            if (cmd_valid && cmd_ready) begin
                cmd_valid <= 1'b0;
            end
            if (take) begin
                hi_half <= !hi_half;
                // second byte completes the word
                if (hi_half) begin
                    cmd_valid <= 1'b1;
                end
            end
        end
    end

    // low byte first, then high byte
    always_ff @(posedge clk) begin
        if (take) begin
            if (hi_half) begin
                cmd[BW +: BW] <= rx_data;
            end else begin
                cmd[0 +: BW] <= rx_data;
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/word_unpacker.sv ====
`timescale 1ns/1ps
`default_nettype none

module word_unpacker (
    input  wire                          clk,
    input  wire                          arstn,
    input  wire uart_proc_pkg::result_word_t result,
    input  wire                          result_valid,
    input  wire                          tx_ready,
    output logic                         result_ready,
    output uart_proc_pkg::uart_byte_t    tx_data,
    output logic                         tx_valid
);
    localparam int BW = uart_proc_pkg::UART_WIDTH;

    uart_proc_pkg::result_word_t word;
    logic                        full;
    // high byte is the one on offer
    logic                        hi_half;

    // new word only into an empty register
    assign result_ready = !full;
    assign tx_valid     = full;
    assign tx_data      = hi_half ? word[BW +: BW] : word[0 +: BW];

    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            full    <= 1'b0;
            hi_half <= 1'b0;
        end else begin
            if (result_valid && result_ready) begin
                full    <= 1'b1;
                hi_half <= 1'b0;
            end else if (tx_valid && tx_ready) begin
                hi_half <= !hi_half;
                // register frees after the high byte leaves
                if (hi_half) begin
                    full <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (result_valid && result_ready) begin
            word <= result;
        end
    end

    // a byte is only offered once a word has been taken from the processor
    assert property (@(posedge clk) disable iff (!arstn)
        $rose(tx_valid) |-> $past(result_valid && result_ready));

endmodule

`default_nettype wire

// ==== logic/command_processor.sv ====
`timescale 1ns/1ps
`default_nettype none

module command_processor (
    input  wire                          clk,
    input  wire                          arstn,
    input  wire uart_proc_pkg::cmd_word_t cmd,
    input  wire                          cmd_valid,
    input  wire                          result_ready,
    output logic                         cmd_ready,
    output uart_proc_pkg::result_word_t  result,
    output logic                         result_valid
);
    typedef enum logic {
        S_ACCEPT,
        S_RUNNING
    } state_e;

    state_e                      state;
    uart_proc_pkg::result_word_t acc;
    // results still owed by the current run
    uart_proc_pkg::operand_t     remaining;
    uart_proc_pkg::opcode_e      opcode;
    uart_proc_pkg::operand_t     operand;

    // opcode in the top bits, operand below
    assign opcode  = uart_proc_pkg::opcode_e'(
        cmd[uart_proc_pkg::INP_WIDTH-1 -: uart_proc_pkg::OPCODE_WIDTH]);
    assign operand = cmd[uart_proc_pkg::OPERAND_WIDTH-1:0];

    // no new command until the run has drained
    assign cmd_ready    = (state == S_ACCEPT);
    assign result_valid = (state == S_RUNNING);
    assign result       = acc;

    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            state     <= S_ACCEPT;
            acc       <= '0;
            remaining <= '0;
        end else begin
            case (state)
                S_ACCEPT: begin
                    if (cmd_valid) begin
                        unique case (opcode)
                            uart_proc_pkg::OP_LOAD:
                                acc <= uart_proc_pkg::result_word_t'(operand);
                            // wraps modulo 2^16
                            uart_proc_pkg::OP_ADD:
                                acc <= acc + uart_proc_pkg::result_word_t'(operand);
                            uart_proc_pkg::OP_CLEAR:
                                acc <= '0;
                            uart_proc_pkg::OP_RUN: begin
                                // run 0 is accepted and emits nothing
                                if (operand != '0) begin
                                    remaining <= operand;
                                    state     <= S_RUNNING;
                                end
                            end
                        endcase
                    end
                end
                S_RUNNING: begin
                    // step the accumulator once per delivered result
                    if (result_ready) begin
                        acc       <= acc + 1'b1;
                        remaining <= remaining - 1'b1;
                        if (remaining == uart_proc_pkg::operand_t'(1)) begin
                            state <= S_ACCEPT;
                        end
                    end
                end
                default: state <= S_ACCEPT;
            endcase
        end
    end

    // results only while a run still owes some
    assert property (@(posedge clk) disable iff (!arstn)
        result_valid |-> remaining != '0);

endmodule

`default_nettype wire

// ==== logic/uart_processor.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "uart_proc_macros.svh"

module uart_processor #(
    parameter int CLK_FREQ_HZ = 125_000_000,
    parameter int BAUD_RATE   = 115_200
) (
    input  wire  clk,
    input  wire  arstn,
    input  wire  rxd,
    output logic txd,
    output logic rx_busy,
    output logic tx_busy,
    output logic rx_error
);
    // bit period in clocks, both uart ends need at least 4
    localparam int CLKS_PER_BIT = `clk_per_bit(CLK_FREQ_HZ, BAUD_RATE);

    // receive path
    uart_proc_pkg::uart_byte_t    rx_data;
    logic                         rx_valid;
    logic                         rx_ready;
    logic                         frame_error;
    logic                         overrun_error;
    uart_proc_pkg::cmd_word_t     cmd;
    logic                         cmd_valid;
    logic                         cmd_ready;

    // transmit path
    uart_proc_pkg::result_word_t  result;
    logic                         result_valid;
    logic                         result_ready;
    uart_proc_pkg::uart_byte_t    tx_data;
    logic                         tx_valid;
    logic                         tx_ready;

    uart_rx #(
        .CLKS_PER_BIT(CLKS_PER_BIT)
    ) i_rx (
        .clk,
        .arstn,
        .rxd,
        .rx_ready,
        .rx_data,
        .rx_valid,
        .rx_busy,
        .frame_error,
        .overrun_error
    );

    byte_packer i_packer (
        .clk,
        .arstn,
        .rx_data,
        .rx_valid,
        .cmd_ready,
        .rx_ready,
        .cmd,
        .cmd_valid
    );

    command_processor i_proc (
        .clk,
        .arstn,
        .cmd,
        .cmd_valid,
        .result_ready,
        .cmd_ready,
        .result,
        .result_valid
    );

    word_unpacker i_unpacker (
        .clk,
        .arstn,
        .result,
        .result_valid,
        .tx_ready,
        .result_ready,
        .tx_data,
        .tx_valid
    );

    uart_tx #(
        .CLKS_PER_BIT(CLKS_PER_BIT)
    ) i_tx (
        .clk,
        .arstn,
        .tx_data,
        .tx_valid,
        .tx_ready,
        .txd,
        .tx_busy
    );

    // host cannot be stalled, so lost bytes are only flagged
    // sticky until reset
    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            rx_error <= 1'b0;
        end else if (frame_error || overrun_error) begin
            rx_error <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== dv/tb_uart_processor.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_uart_processor;
    localparam int CLK_FREQ_HZ = 125_000_000;
    localparam int BAUD_RATE = 7_812_500;
    // clocks per serial bit at these rates
    localparam int CPB = 16;

    logic clk;
    logic arstn;
    logic rxd;
    logic txd;
    logic rx_busy;
    logic tx_busy;
    logic rx_error;

    // parsed test script
    int         ids[$];
    logic [7:0] kinds[$];
    logic [15:0] values[$];
    logic       script_loaded;

    // words the DUT still owes on txd, in order
    logic [15:0] expected_q[$];
    // set by the monitor while a low byte waits for its high byte
    logic        have_low;
    logic [7:0]  low_byte;
    int          err_count;

    uart_processor #(
        .CLK_FREQ_HZ(CLK_FREQ_HZ),
        .BAUD_RATE(BAUD_RATE)
    ) i_dut (
        .clk(clk),
        .arstn(arstn),
        .rxd(rxd),
        .txd(txd),
        .rx_busy(rx_busy),
        .tx_busy(tx_busy),
        .rx_error(rx_error)
    );

    always #4 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("error: %s got 0x%0h expected 0x%0h", name, got, exp);
            err_count++;
        end
    endtask

    // one serial bit, set on a rising edge and held for the given clocks
    task automatic drive_bit(input logic value, input int cycles);
        @(posedge clk);
        rxd <= value;
        repeat (cycles - 1) @(posedge clk);
    endtask

    task automatic send_byte(input logic [7:0] data, input logic good_stop);
        int i;
        drive_bit(1'b0, CPB);
        // receiver has seen the start bit by its end
        check_value("rx_busy", rx_busy, 1);
        for (i = 0; i < 8; i++) begin
            drive_bit(data[i], CPB);
        end
        if (good_stop) begin
            drive_bit(1'b1, CPB);
        end else begin
            // low across the mid-bit sample, released early
            // so the receiver's start filter rejects the tail
            drive_bit(1'b0, CPB * 3 / 4);
            drive_bit(1'b1, CPB - CPB * 3 / 4);
        end
        // idle gap between frames
        drive_bit(1'b1, 2 * CPB);
        // receiver back in idle before the next frame
        check_value("rx_busy", rx_busy, 0);
    endtask

    task automatic pulse_reset();
        @(posedge clk);
        arstn <= 1'b0;
        repeat (10) @(posedge clk);
        arstn <= 1'b1;
        have_low = 1'b0;
    endtask

    // decode txd frames, pair bytes into words and compare
    always begin
        logic [7:0] data;
        logic [15:0] word;
        int i;
        @(posedge clk);
        if (arstn && txd === 1'b0) begin
            // first low sample is one clock into the start bit
            repeat (CPB / 2 - 1) @(posedge clk);
            if (txd !== 1'b0) begin
                $display("txd start bit did not hold low to its middle");
                err_count++;
            end else begin
                // transmitter flags the frame in flight
                check_value("tx_busy", tx_busy, 1);
                for (i = 0; i < 8; i++) begin
                    repeat (CPB) @(posedge clk);
                    data[i] = txd;
                end
                repeat (CPB) @(posedge clk);
                if (txd !== 1'b1) begin
                    $display("txd stop bit was low, byte 0x%0h framed badly", data);
                    err_count++;
                end
                if (!have_low) begin
                    low_byte = data;
                    have_low = 1'b1;
                end else begin
                    word = {data, low_byte};
                    have_low = 1'b0;
                    if (expected_q.size() == 0) begin
                        $display("unexpected result word 0x%0h arrived on txd", word);
                        err_count++;
                    end else begin
                        check_value("result", word, expected_q.pop_front());
                    end
                end
            end
        end
    end

    task automatic load_script(output logic ok);
        int fd;
        int n;
        int t;
        logic [7:0] k;
        logic [15:0] v;
        logic [8*96-1:0] line;
        ok = 1'b0;
        fd = $fopen("dv/proc_tests.txt", "r");
        if (fd != 0) begin
            while (!$feof(fd)) begin
                line = '0;
                n = $fgets(line, fd);
                // comment and blank lines do not parse as three fields
                if (n > 0 && $sscanf(line, "%d %c %h", t, k, v) == 3) begin
                    ids.push_back(t);
                    kinds.push_back(k);
                    values.push_back(v);
                end
            end
            $fclose(fd);
            ok = (ids.size() > 0);
        end
    endtask

    task automatic run_line(input logic [7:0] k, input logic [15:0] v);
        case (k)
            "c": begin
                send_byte(v[7:0], 1'b1);
                send_byte(v[15:8], 1'b1);
            end
            "e": expected_q.push_back(v);
            "b": send_byte(v[7:0], 1'b0);
            "h": check_value("rx_error", rx_error, 1);
            "l": check_value("rx_error", rx_error, 0);
            "r": pulse_reset();
            default: begin
                $display("test script holds an unknown line kind '%c'", k);
                err_count++;
            end
        endcase
    endtask

    // drain the expected queue, then stay quiet to catch extra words
    task automatic finish_test(input int id, input int errs_before, inout int passed,
                               inout int failed);
        int waited;
        int limit;
        waited = 0;
        limit = (expected_q.size() + 1) * 30 * CPB;
        while (expected_q.size() != 0 && waited < limit) begin
            @(posedge clk);
            waited++;
        end
        if (expected_q.size() != 0) begin
            $display("test %0d: %0d expected result words never arrived on txd", id,
                     expected_q.size());
            err_count++;
            expected_q.delete();
        end
        repeat (24 * CPB) @(posedge clk);
        // both serial ends idle between tests
        check_value("rx_busy", rx_busy, 0);
        check_value("tx_busy", tx_busy, 0);
        if (err_count == errs_before) begin
            $display("test %0d passed", id);
            passed++;
        end else begin
            $display("test %0d failed with %0d errors", id, err_count - errs_before);
            failed++;
        end
    endtask

    initial begin : main
        logic ok;
        int i;
        int errs_before;
        int passed;
        int failed;
        clk = 1'b0;
        arstn = 1'b0;
        rxd = 1'b1;
        script_loaded = 1'b0;
        have_low = 1'b0;
        low_byte = '0;
        err_count = 0;
        passed = 0;
        failed = 0;
        load_script(ok);
        if (!ok) begin
            $display("could not read any test lines from dv/proc_tests.txt");
            $display("*** TEST FAILED ***");
            $finish;
        end else begin
            script_loaded = 1'b1;
            pulse_reset();
            errs_before = err_count;
            for (i = 0; i < ids.size(); i++) begin
                if (i > 0 && ids[i] != ids[i-1]) begin
                    finish_test(ids[i-1], errs_before, passed, failed);
                    errs_before = err_count;
                end
                run_line(kinds[i], values[i]);
            end
            finish_test(ids[ids.size()-1], errs_before, passed, failed);
            $display("tests passed %0d failed %0d errors %0d", passed, failed, err_count);
            if (err_count == 0 && failed == 0) begin
                $display("*** TEST PASSED ***");
            end else begin
                $display("*** TEST FAILED ***");
            end
            $finish;
        end
    end

    // each script line gets 40 bit periods, plus some slack
    initial begin : watchdog
        wait (script_loaded);
        repeat (ids.size() * 40 * CPB + 200 * CPB) @(posedge clk);
        $display("timeout: the test script did not finish in the allowed time");
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

// ==== proc_uart.f ====
+incdir+include
logic/uart_proc_pkg.sv
logic/uart_rx.sv
logic/uart_tx.sv
logic/byte_packer.sv
logic/word_unpacker.sv
logic/command_processor.sv
logic/uart_processor.sv
dv/tb_uart_processor.sv

// ==== dv/proc_tests.txt ====
# columns: test number, kind, value in hex
# kinds: e queue expected result word (listed before the command that produces it),
#        c send command word low byte first, b send byte with bad stop bit,
#        h rx_error must be high, l rx_error must be low, r pulse reset
1 e 1234
1 e 1235
1 e 1236
1 c 1234
1 c 8003
2 e 3ffb
2 c 3fff
2 c 7fff
2 c 7fff
2 c 7fff
2 c 7fff
2 c 8001
3 e 0000
3 e 0001
3 e 0002
3 c c000
3 c 8000
3 c 8001
3 c 8002
4 e 0100
4 e 0101
4 e 0102
4 e 0103
4 e 0104
4 e 0105
4 e 0106
4 c 0100
4 c 8005
4 c 8002
4 l 0
5 b a5
5 h 0
5 e 0042
5 e 0043
5 c 0042
5 c 8002
5 h 0
6 r 0
6 l 0
6 e 0000
6 c 8001
